// ==== compile.f ====
+incdir+include
rtl/cpu_pkg.sv
rtl/cpuFetch.sv
rtl/cpuDecode.sv
rtl/cpuExecute.sv
rtl/cpuResult.sv
rtl/cpu.sv
sim/cpuTb.sv

// ==== sim/cpuTb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module cpuTb;

  import cpu_pkg::*;

  localparam int ClkPeriod   = 8;
  localparam int ResetCycles = 16;
  localparam int NumRows     = 16;  // One row per program word loaded in reset
  localparam int HaltRow     = 15;  // Row that holds HLT
  localparam int HoldCycles  = 8;   // Cycles watched once hlt is up
  localparam int WatchCycles = ResetCycles + 4 * NumRows + 40;

  localparam condCode CondEq = 3'b001;
  localparam condCode CondLt = 3'b011;

  // DUT inputs
  logic clk;
  logic reset;
  logic loadEnable;
  dataWord loadAddr;
  dataWord loadData;

  // DUT outputs
  wire logic hlt;
  wire dataWord pc;
  wire logic retireValid;
  wire regIndex retireReg;
  wire dataWord retireData;

  // Program table with the word of each row at byte address 2*row
  dataWord progInstr [NumRows];
  logic progRetires [NumRows];  // Row writes a register
  regIndex progDest [NumRows];
  dataWord progData [NumRows];

  cpu u_dut (
    .clk        (clk),
    .reset      (reset),
    .loadEnable (loadEnable),
    .loadAddr   (loadAddr),
    .loadData   (loadData),
    .hlt        (hlt),
    .pc         (pc),
    .retireValid(retireValid),
    .retireReg  (retireReg),
    .retireData (retireData)
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  // Run limit from reset length and table size
  initial begin
    repeat (WatchCycles) @(posedge clk);
    $display("Timeout: the program did not halt within %0d cycles", WatchCycles);
    $display("Some tests failed");
    $fatal(1, "Watchdog expired");
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////
  task automatic checkValue(input string name, input logic [15:0] actual,
                            input logic [15:0] expected);
    if (actual !== expected) begin
      $display("ERROR at time %0t: %s is %h, expected %h", $time, name, actual, expected);
      $display("Some tests failed");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  // Register form also covers shifts (rt is the amount) and LW/SW (rt is the offset)
  function automatic dataWord packRegOp(input opCode op, input regIndex rd,
                                        input regIndex rs, input logic [3:0] rt);
    return {op, rd, rs, rt};
  endfunction

  function automatic dataWord packByteOp(input opCode op, input regIndex rd,
                                         input logic [7:0] imm);
    return {op, rd, imm};
  endfunction

  function automatic dataWord packBranch(input condCode cond, input logic [8:0] offset);
    return {`CPU_OP_B, cond, offset};  // Offset in words from PC plus 2
  endfunction

  task automatic setRow(input int idx, input dataWord instr, input logic retires,
                        input regIndex dest, input dataWord data);
    progInstr[idx]   = instr;
    progRetires[idx] = retires;
    progDest[idx]    = dest;
    progData[idx]    = data;
  endtask

  // Next retiring row at or after start or NumRows when none is left
  function automatic int nextRetiring(input int start);
    int idx;
    idx = start;
    while (idx < NumRows && !progRetires[idx]) begin
      idx++;
    end
    return idx;
  endfunction

  task automatic driveLoad(input int idx);
    if (idx < NumRows) begin
      loadEnable <= 1'b1;
      loadAddr   <= dataWord'(2 * idx);
      loadData   <= progInstr[idx];
    end else begin
      loadEnable <= 1'b0;
    end
  endtask

  ////////////////////////////////////////
  // Program and expected retires
  ////////////////////////////////////////
  task automatic buildProgram();
    setRow(0, packRegOp(`CPU_OP_PCS, 4'd1, 4'd0, 4'd0), 1'b1, 4'd1, 16'h0002);
    setRow(1, packByteOp(`CPU_OP_LLB, 4'd1, 8'h34), 1'b1, 4'd1, 16'h0034);
    setRow(2, packByteOp(`CPU_OP_LHB, 4'd1, 8'h92), 1'b1, 4'd1, 16'h9234);
    setRow(3, packRegOp(`CPU_OP_SRA, 4'd2, 4'd1, 4'd4), 1'b1, 4'd2, 16'hF923);
    setRow(4, packRegOp(`CPU_OP_XOR, 4'd3, 4'd2, 4'd1), 1'b1, 4'd3, 16'h6B17);
    setRow(5, packRegOp(`CPU_OP_SLL, 4'd4, 4'd3, 4'd3), 1'b1, 4'd4, 16'h58B8);
    setRow(6, packRegOp(`CPU_OP_ADD, 4'd0, 4'd4, 4'd3), 1'b0, 4'd0, 16'h0000);  // r0 dropped
    setRow(7, packBranch(CondEq, 9'd2), 1'b0, 4'd0, 16'h0000);  // Z clear so it falls through
    setRow(8, packRegOp(`CPU_OP_SW, 4'd4, 4'd0, 4'd2), 1'b0, 4'd0, 16'h0000);   // Byte addr 4
    setRow(9, packRegOp(`CPU_OP_LW, 4'd5, 4'd0, 4'd2), 1'b1, 4'd5, 16'h58B8);
    setRow(10, packRegOp(`CPU_OP_SUB, 4'd6, 4'd0, 4'd5), 1'b1, 4'd6, 16'hA748);  // Load-use
    setRow(11, packBranch(CondLt, 9'd2), 1'b0, 4'd0, 16'h0000);  // N set so it jumps to 0x1C
    setRow(12, packRegOp(`CPU_OP_ADD, 4'd7, 4'd1, 4'd1), 1'b0, 4'd0, 16'h0000);  // Shadow
    setRow(13, packRegOp(`CPU_OP_ADD, 4'd7, 4'd2, 4'd2), 1'b0, 4'd0, 16'h0000);  // Shadow
    setRow(14, packRegOp(`CPU_OP_ADD, 4'd7, 4'd3, 4'd4), 1'b1, 4'd7, 16'hC3CF);  // Target
    setRow(HaltRow, packRegOp(`CPU_OP_HLT, 4'd0, 4'd0, 4'd0), 1'b0, 4'd0, 16'h0000);
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////
  initial begin
    int expectIdx;
    dataWord haltPc;
    buildProgram();
    reset      = 1'b1;
    loadEnable = 1'b1;          // Word 0 waits on the load port for the first edge
    loadAddr   = '0;
    loadData   = progInstr[0];
    for (int k = 1; k < ResetCycles; k++) begin
      @(posedge clk);
      driveLoad(k);
    end
    @(posedge clk);
    reset      <= 1'b0;         // Last word is written at this edge
    loadEnable <= 1'b0;

    // Each retire matches the next retiring row in program order
    expectIdx = nextRetiring(0);
    while (expectIdx < NumRows) begin
      @(negedge clk);
      checkValue("hlt", 16'(hlt), 16'h0000);
      if (retireValid !== 1'b0) begin
        checkValue("retireReg", 16'(retireReg), 16'(progDest[expectIdx]));
        checkValue("retireData", retireData, progData[expectIdx]);
        expectIdx = nextRetiring(expectIdx + 1);
      end
    end

    // Nothing else retires on the way to halt
    do begin
      @(negedge clk);
      checkValue("retireValid", 16'(retireValid), 16'h0000);
    end while (hlt !== 1'b1);

    haltPc = dataWord'(2 * HaltRow);  // PC parks on the HLT word
    checkValue("pc", pc, haltPc);
    repeat (HoldCycles) begin
      @(negedge clk);
      checkValue("hlt", 16'(hlt), 16'h0001);
      checkValue("pc", pc, haltPc);
      checkValue("retireValid", 16'(retireValid), 16'h0000);
    end

    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== rtl/cpu.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu (
  input wire logic clk,
  input wire logic reset,
  input wire logic loadEnable,
  input wire cpu_pkg::dataWord loadAddr,
  input wire cpu_pkg::dataWord loadData,
  output wire logic hlt,
  output wire cpu_pkg::dataWord pc,
  output wire logic retireValid,
  output wire cpu_pkg::regIndex retireReg,
  output wire cpu_pkg::dataWord retireData
);

  import cpu_pkg::*;

  // Fetch to decode
  dataWord instr;
  dataWord pcNext;
  logic fetchValid;
  logic haltSeen;
  logic redirect;      // From execute
  dataWord redirectPc;

  // Decode/execute stage
  logic exValid;
  aluFunc exFunc;
  dataWord exOperandA;
  dataWord exOperandB;
  dataWord exImm;
  logic exUseImm;
  regIndex exSrcA;
  regIndex exSrcB;
  regIndex exDest;
  logic exRegWrite;
  logic exMemRead;
  logic exMemWrite;
  wbSource exWbSource;
  logic exSetZ;
  logic exSetNV;
  logic exBranch;
  condCode exCond;
  dataWord exBranchTarget;
  dataWord exPcNext;
  logic exHalt;

  // Execute/result stage
  logic resValid;
  dataWord resAlu;
  dataWord resStoreData;
  regIndex resDest;
  logic resRegWrite;
  logic resMemRead;
  logic resMemWrite;
  wbSource resWbSource;
  dataWord resPcNext;
  logic resHalt;

  // Write-back, back to decode and execute
  logic wbWrite;
  regIndex wbDest;
  dataWord wbData;

  ////////////////////////////////////////
  // Pipeline stages, ports match by name
  ////////////////////////////////////////
  cpuFetch u_fetch (.*);

  cpuDecode u_decode (.*);

  cpuExecute u_execute (.*);

  cpuResult u_result (.*);

  // Retire port mirrors the register write
  assign retireValid = wbWrite;
  assign retireReg   = wbDest;
  assign retireData  = wbData;

endmodule

`default_nettype wire

// ==== rtl/cpuResult.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module cpuResult (
  input wire logic clk,
  input wire logic reset,
  input wire logic resValid,
  input wire cpu_pkg::dataWord resAlu,
  input wire cpu_pkg::dataWord resStoreData,
  input wire cpu_pkg::regIndex resDest,
  input wire logic resRegWrite,
  input wire logic resMemRead,
  input wire logic resMemWrite,
  input wire cpu_pkg::wbSource resWbSource,
  input wire cpu_pkg::dataWord resPcNext,
  input wire logic resHalt,
  output logic wbWrite,
  output cpu_pkg::regIndex wbDest,
  output cpu_pkg::dataWord wbData,
  output logic hlt
);

  import cpu_pkg::*;

  localparam int DmemAw = $clog2(`CPU_DMEM_DEPTH);

  dataWord dmem [`CPU_DMEM_DEPTH];
  dataWord memData;
  logic hltQ;  // HLT has retired

  ////////////////////////////////////////
  // Data memory
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (resValid && resMemWrite) begin
      dmem[resAlu[DmemAw:1]] <= resStoreData;  // Byte address to word index
    end
  end

  assign memData = resMemRead ? dmem[resAlu[DmemAw:1]] : '0;  // Same-cycle read

  // Write-back select
  always_comb begin
    case (resWbSource)
      wbMemory: wbData = memData;
      wbLinkPc: wbData = resPcNext;  // PCS
      default:  wbData = resAlu;
    endcase
  end

  assign wbWrite = resValid & resRegWrite;
  assign wbDest  = resDest;

  always_ff @(posedge clk) begin
    if (reset) begin
      hltQ <= 1'b0;
    end else begin
      hltQ <= hlt;
    end
  end

  assign hlt = hltQ | (resValid & resHalt);  // Rises with HLT in this stage

endmodule

`default_nettype wire

// ==== rtl/cpuExecute.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module cpuExecute (
  input wire logic clk,
  input wire logic reset,
  input wire logic exValid,
  input wire cpu_pkg::aluFunc exFunc,
  input wire cpu_pkg::dataWord exOperandA,
  input wire cpu_pkg::dataWord exOperandB,
  input wire cpu_pkg::dataWord exImm,
  input wire logic exUseImm,
  input wire cpu_pkg::regIndex exSrcA,
  input wire cpu_pkg::regIndex exSrcB,
  input wire cpu_pkg::regIndex exDest,
  input wire logic exRegWrite,
  input wire logic exMemRead,
  input wire logic exMemWrite,
  input wire cpu_pkg::wbSource exWbSource,
  input wire logic exSetZ,
  input wire logic exSetNV,
  input wire logic exBranch,
  input wire cpu_pkg::condCode exCond,
  input wire cpu_pkg::dataWord exBranchTarget,
  input wire cpu_pkg::dataWord exPcNext,
  input wire logic exHalt,
  input wire logic wbWrite,
  input wire cpu_pkg::regIndex wbDest,
  input wire cpu_pkg::dataWord wbData,
  output logic redirect,
  output cpu_pkg::dataWord redirectPc,
  output logic resValid,
  output cpu_pkg::dataWord resAlu,
  output cpu_pkg::dataWord resStoreData,
  output cpu_pkg::regIndex resDest,
  output logic resRegWrite,
  output logic resMemRead,
  output logic resMemWrite,
  output cpu_pkg::wbSource resWbSource,
  output cpu_pkg::dataWord resPcNext,
  output logic resHalt
);

  import cpu_pkg::*;

  localparam int Msb = `CPU_DATA_W - 1;

  dataWord opA;     // Forwarded operands
  dataWord opB;
  dataWord aluB;
  dataWord aluOut;
  logic vNext;
  logic flagZ;
  logic flagN;
  logic flagV;
  logic taken;

  ////////////////////////////////////////
  // Forwarding from the result stage
  ////////////////////////////////////////
  assign opA  = (wbWrite && exSrcA != '0 && wbDest == exSrcA) ? wbData : exOperandA;
  assign opB  = (wbWrite && exSrcB != '0 && wbDest == exSrcB) ? wbData : exOperandB;
  assign aluB = exUseImm ? exImm : opB;

  // ALU
  always_comb begin
    vNext = 1'b0;
    case (exFunc)
      aluAdd: begin
        aluOut = opA + aluB;
        vNext  = (opA[Msb] == aluB[Msb]) && (aluOut[Msb] != opA[Msb]);  // Like signs in
      end
      aluSub: begin
        aluOut = opA - aluB;
        vNext  = (opA[Msb] != aluB[Msb]) && (aluOut[Msb] != opA[Msb]);
      end
      aluXor:      aluOut = opA ^ aluB;
      aluSll:      aluOut = opA << aluB[3:0];
      aluSra:      aluOut = dataWord'($signed(opA) >>> aluB[3:0]);  // Sign fill
      aluPassLow:  aluOut = {opA[Msb:8], aluB[7:0]};
      aluPassHigh: aluOut = {aluB[7:0], opA[7:0]};
      default:     aluOut = opA;
    endcase
  end

  ////////////////////////////////////////
  // Flags and branch resolution
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      flagZ <= 1'b0;
      flagN <= 1'b0;
      flagV <= 1'b0;
    end else if (exValid) begin
      if (exSetZ) begin
        flagZ <= (aluOut == '0);
      end
      if (exSetNV) begin
        flagN <= aluOut[Msb];
        flagV <= vNext;
      end
    end
  end

  always_comb begin
    case (exCond)
      3'b000:  taken = ~flagZ;            // NE
      3'b001:  taken = flagZ;             // EQ
      3'b010:  taken = ~flagZ & ~flagN;   // GT
      3'b011:  taken = flagN;             // LT
      3'b100:  taken = flagZ | ~flagN;    // GE
      3'b101:  taken = flagZ | flagN;     // LE
      3'b110:  taken = flagV;             // Overflow
      default: taken = 1'b1;              // Always
    endcase
  end

  assign redirect   = exValid & exBranch & taken;
  assign redirectPc = exBranchTarget;

  ////////////////////////////////////////
  // Execute/result register
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      resValid <= 1'b0;
    end else begin
      resValid <= exValid;
    end
  end

  always_ff @(posedge clk) begin
    resAlu       <= aluOut;  // Also the data address
    resStoreData <= opB;
    resDest      <= exDest;
    resRegWrite  <= exRegWrite;
    resMemRead   <= exMemRead;
    resMemWrite  <= exMemWrite;
    resWbSource  <= exWbSource;
    resPcNext    <= exPcNext;
    resHalt      <= exHalt;
  end

endmodule

`default_nettype wire

// ==== rtl/cpuDecode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module cpuDecode (
  input wire logic clk,
  input wire logic reset,
  input wire cpu_pkg::dataWord instr,
  input wire cpu_pkg::dataWord pcNext,
  input wire logic fetchValid,
  input wire logic redirect,
  input wire logic wbWrite,
  input wire cpu_pkg::regIndex wbDest,
  input wire cpu_pkg::dataWord wbData,
  output logic exValid,
  output cpu_pkg::aluFunc exFunc,
  output cpu_pkg::dataWord exOperandA,
  output cpu_pkg::dataWord exOperandB,
  output cpu_pkg::dataWord exImm,
  output logic exUseImm,
  output cpu_pkg::regIndex exSrcA,
  output cpu_pkg::regIndex exSrcB,
  output cpu_pkg::regIndex exDest,
  output logic exRegWrite,
  output logic exMemRead,
  output logic exMemWrite,
  output cpu_pkg::wbSource exWbSource,
  output logic exSetZ,
  output logic exSetNV,
  output logic exBranch,
  output cpu_pkg::condCode exCond,
  output cpu_pkg::dataWord exBranchTarget,
  output cpu_pkg::dataWord exPcNext,
  output logic exHalt,
  output logic haltSeen
);

  import cpu_pkg::*;

  dataWord regs [2**`CPU_REG_W];  // r0 slot is never written
  logic haltQ;                    // Sticky, HLT already decoded
  logic decValid;
  opCode op;
  regIndex rdField;               // Also rt of LW/SW
  regIndex rsField;
  regIndex rtField;
  regIndex srcA;
  regIndex srcB;
  regIndex dest;
  dataWord readA;
  dataWord readB;
  dataWord imm;
  dataWord target;
  aluFunc func;
  wbSource wbSel;
  logic useImm;
  logic regWrite;
  logic memRead;
  logic memWrite;
  logic setZ;
  logic setNV;
  logic branch;
  logic isHalt;

  assign op       = instr[15:12];
  assign rdField  = instr[11:8];
  assign rsField  = instr[7:4];
  assign rtField  = instr[3:0];
  assign decValid = fetchValid & ~haltQ;  // Repeats of a held HLT are bubbles
  assign haltSeen = haltQ | (decValid & isHalt);

  // PC plus 2 plus sign-extended 9-bit word offset
  assign target = pcNext + {{6{instr[8]}}, instr[8:0], 1'b0};

  ////////////////////////////////////////
  // Register file
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (wbWrite && wbDest != '0) begin
      regs[wbDest] <= wbData;
    end
  end

  // r0 reads zero, same-cycle write shows through
  assign readA = (srcA == '0) ? '0 : (wbWrite && wbDest == srcA) ? wbData : regs[srcA];
  assign readB = (srcB == '0) ? '0 : (wbWrite && wbDest == srcB) ? wbData : regs[srcB];

  ////////////////////////////////////////
  // Control decode
  ////////////////////////////////////////
  always_comb begin
    func     = aluAdd;
    imm      = '0;
    useImm   = 1'b0;
    srcA     = rsField;
    srcB     = rtField;
    dest     = rdField;
    regWrite = 1'b0;
    memRead  = 1'b0;
    memWrite = 1'b0;
    wbSel    = wbAlu;
    setZ     = 1'b0;
    setNV    = 1'b0;
    branch   = 1'b0;
    isHalt   = 1'b0;
    case (op)
      `CPU_OP_ADD, `CPU_OP_SUB: begin
        func     = (op == `CPU_OP_SUB) ? aluSub : aluAdd;
        regWrite = 1'b1;
        setZ     = 1'b1;
        setNV    = 1'b1;
      end
      `CPU_OP_XOR: begin
        func     = aluXor;
        regWrite = 1'b1;
        setZ     = 1'b1;
      end
      `CPU_OP_SLL, `CPU_OP_SRA: begin
        func     = (op == `CPU_OP_SRA) ? aluSra : aluSll;
        imm      = {12'h000, rtField};  // Shift amount
        useImm   = 1'b1;
        regWrite = 1'b1;
        setZ     = 1'b1;
      end
      `CPU_OP_LW: begin
        imm      = {{11{instr[3]}}, instr[3:0], 1'b0};  // Word offset in bytes
        useImm   = 1'b1;
        memRead  = 1'b1;
        regWrite = 1'b1;
        wbSel    = wbMemory;
      end
      `CPU_OP_SW: begin
        imm      = {{11{instr[3]}}, instr[3:0], 1'b0};
        useImm   = 1'b1;
        srcB     = rdField;  // Store data
        memWrite = 1'b1;
      end
      `CPU_OP_LLB, `CPU_OP_LHB: begin
        func     = (op == `CPU_OP_LHB) ? aluPassHigh : aluPassLow;
        srcA     = rdField;  // Other byte of rd survives
        imm      = {8'h00, instr[7:0]};
        useImm   = 1'b1;
        regWrite = 1'b1;
      end
      `CPU_OP_B:   branch = 1'b1;
      `CPU_OP_PCS: begin
        regWrite = 1'b1;
        wbSel    = wbLinkPc;
      end
      `CPU_OP_HLT: isHalt = 1'b1;
      default: ;  // Unused opcodes run as no-ops
    endcase
  end

  ////////////////////////////////////////
  // Decode/execute register
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      exValid <= 1'b0;
      haltQ   <= 1'b0;
    end else begin
      exValid <= decValid & ~redirect;  // Younger than a taken branch
      haltQ   <= haltSeen;
    end
  end

  always_ff @(posedge clk) begin
    exFunc         <= func;
    exOperandA     <= readA;
    exOperandB     <= readB;
    exImm          <= imm;
    exUseImm       <= useImm;
    exSrcA         <= srcA;
    exSrcB         <= srcB;
    exDest         <= dest;
    exRegWrite     <= regWrite & (dest != '0);  // Writes to r0 are dropped
    exMemRead      <= memRead;
    exMemWrite     <= memWrite;
    exWbSource     <= wbSel;
    exSetZ         <= setZ;
    exSetNV        <= setNV;
    exBranch       <= branch;
    exCond         <= instr[11:9];
    exBranchTarget <= target;
    exPcNext       <= pcNext;
    exHalt         <= isHalt;
  end

endmodule

`default_nettype wire

// ==== rtl/cpuFetch.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module cpuFetch (
  input wire logic clk,
  input wire logic reset,
  input wire logic loadEnable,
  input wire cpu_pkg::dataWord loadAddr,
  input wire cpu_pkg::dataWord loadData,
  input wire logic redirect,
  input wire cpu_pkg::dataWord redirectPc,
  input wire logic haltSeen,
  output cpu_pkg::dataWord pc,
  output cpu_pkg::dataWord instr,
  output cpu_pkg::dataWord pcNext,
  output logic fetchValid
);

  import cpu_pkg::*;

  localparam int ImemAw = $clog2(`CPU_IMEM_DEPTH);

  dataWord imem [`CPU_IMEM_DEPTH];  // Program store
  logic live;                       // Low in reset and for the first cycle after it

  // Program load, only while the core sits in reset
  always_ff @(posedge clk) begin
    if (reset && loadEnable) begin
      imem[loadAddr[ImemAw:1]] <= loadData;  // Byte address to word index
    end
  end

  ////////////////////////////////////////
  // PC register
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      pc   <= `CPU_RESET_PC;
      live <= 1'b0;
    end else begin
      live <= 1'b1;
      if (redirect) begin
        pc <= redirectPc;  // Taken branch from execute
      end else if (live && !haltSeen) begin
        pc <= pcNext;      // Hold once HLT is decoded
      end
    end
  end

  assign instr      = imem[pc[ImemAw:1]];  // Combinational read
  assign pcNext     = pc + dataWord'(2);
  assign fetchValid = live & ~redirect;    // Branch shadow is dropped

endmodule

`default_nettype wire

// ==== rtl/cpu_pkg.sv ====
`default_nettype none

`include "cpu_consts.svh"

package cpu_pkg;

  typedef logic [`CPU_DATA_W-1:0] dataWord;  // Register values, ALU results, addresses
  typedef logic [`CPU_REG_W-1:0] regIndex;   // Register number
  typedef logic [`CPU_OP_W-1:0] opCode;      // Instruction bits 15:12
  typedef logic [`CPU_COND_W-1:0] condCode;  // Branch condition bits 11:9

  // ALU operation picked in decode
  typedef enum logic [2:0] {
    aluAdd,
    aluSub,
    aluXor,
    aluSll,
    aluSra,
    aluPassLow,   // LLB, keep high byte of rd
    aluPassHigh   // LHB, keep low byte of rd
  } aluFunc;

  // Source of the write-back value
  typedef enum logic [1:0] {
    wbAlu,
    wbMemory,
    wbLinkPc  // PCS writes PC plus 2
  } wbSource;

endpackage

`default_nettype wire

// ==== include/cpu_consts.svh ====
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Datapath widths
`define CPU_DATA_W 16  // Data words and byte addresses
`define CPU_REG_W 4    // Register index, sixteen registers
`define CPU_OP_W 4     // Top nibble of the instruction
`define CPU_COND_W 3   // Branch condition field

// Memory sizes in 16-bit words
`define CPU_IMEM_DEPTH 256
`define CPU_DMEM_DEPTH 256

`define CPU_RESET_PC 16'h0000  // First fetch address

// Opcode encodings
`define CPU_OP_ADD 4'h0
`define CPU_OP_SUB 4'h1
`define CPU_OP_XOR 4'h2
`define CPU_OP_SLL 4'h4
`define CPU_OP_SRA 4'h5
`define CPU_OP_LW 4'h8
`define CPU_OP_SW 4'h9
`define CPU_OP_LLB 4'hA
`define CPU_OP_LHB 4'hB
`define CPU_OP_B 4'hC
`define CPU_OP_PCS 4'hE
`define CPU_OP_HLT 4'hF

`endif
